/* conv_settings.svh */
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// Feature and weight width
`define CONV_DATA_W 16
// Accumulator width, results wrap here
`define CONV_ACC_W 32

// Values per feature window
`define CONV_NB_TAPS 9
`define CONV_NB_OUT_CH 4 // One MAC per output channel

`endif

/* conv_pkg.sv */
`include "conv_settings.svh"

package conv_pkg;

  // One signed feature or weight value
  typedef logic signed [`CONV_DATA_W-1:0] data_t;
  typedef logic signed [`CONV_ACC_W-1:0] acc_t; // Wrapping dot-product result

  typedef logic [$clog2(`CONV_NB_TAPS)-1:0] tap_idx_t;
  typedef logic [$clog2(`CONV_NB_OUT_CH)-1:0] ch_idx_t;

  // Word on the input port
  typedef struct packed {
    logic  kind;  // 1 for a kernel weight, 0 for a feature value
    data_t value;
  } in_word_t;

  // Word on the output port
  typedef struct packed {
    ch_idx_t ch;
    acc_t    value;
  } result_t;

  typedef enum logic [1:0] {
    IDLE,
    COMMIT,
    RUN,
    DRAIN
  } ctrl_state_e;

endpackage

/* feature_window.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module feature_window import conv_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  shift_en,
  input  data_t value,
  input  logic  commit,
  output data_t window [`CONV_NB_TAPS]
);

  data_t fill [`CONV_NB_TAPS]; // Window the host is loading

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CONV_NB_TAPS; i++) begin
        fill[i]   <= '0;
        window[i] <= '0;
      end
    end else begin
      if (shift_en) begin
        for (int i = 0; i < `CONV_NB_TAPS - 1; i++) begin
          fill[i] <= fill[i+1];
        end
        fill[`CONV_NB_TAPS-1] <= value; // Newest value at the top tap
      end
      // Hand the full window over to the MACs
      if (commit) begin
        window <= fill;
      end
    end
  end

endmodule

/* kernel_store.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module kernel_store import conv_pkg::*; (
  input  logic     clk,
  input  logic     kw_en,
  input  ch_idx_t  kw_ch,
  input  tap_idx_t kw_tap,
  input  data_t    value,
  input  tap_idx_t rd_tap,
  output data_t    column [`CONV_NB_OUT_CH]
);

  // One bank per output channel
  data_t weights [`CONV_NB_OUT_CH][`CONV_NB_TAPS];

  always_ff @(posedge clk) begin
    if (kw_en) begin
      weights[kw_ch][kw_tap] <= value;
    end
  end

  // Every bank reads the same tap, result one cycle later
  always_ff @(posedge clk) begin
    for (int c = 0; c < `CONV_NB_OUT_CH; c++) begin
      column[c] <= weights[c][rd_tap];
    end
  end

endmodule

/* mac_array.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module mac_array import conv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  data_t    window [`CONV_NB_TAPS],
  input  data_t    column [`CONV_NB_OUT_CH],
  input  tap_idx_t rd_tap,
  input  logic     step_valid,
  input  logic     first_step,
  input  logic     capture,
  input  ch_idx_t  out_ch,
  output acc_t     result_value
);

  tap_idx_t tap_d;
  logic     valid_d;
  logic     first_d;
  data_t    feat_sel;
  acc_t     prod [`CONV_NB_OUT_CH];
  acc_t     acc  [`CONV_NB_OUT_CH];
  acc_t     res  [`CONV_NB_OUT_CH]; // Held for the drain

  // Align step controls with the registered kernel read
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_d <= 1'b0;
      first_d <= 1'b0;
    end else begin
      valid_d <= step_valid;
      first_d <= first_step;
    end
  end

  always_ff @(posedge clk) begin
    tap_d <= rd_tap;
  end

  // Tap select mux
  always_comb begin
    feat_sel = '0;
    for (int t = 0; t < `CONV_NB_TAPS; t++) begin
      if (tap_d == tap_idx_t'(t)) begin
        feat_sel = window[t];
      end
    end
  end

  // Products are sign extended to the accumulator width
  always_comb begin
    for (int c = 0; c < `CONV_NB_OUT_CH; c++) begin
      prod[c] = feat_sel * column[c];
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < `CONV_NB_OUT_CH; c++) begin
      if (valid_d) begin
        acc[c] <= first_d ? prod[c] : acc[c] + prod[c]; // First tap restarts the sum
      end
      if (capture) begin
        res[c] <= acc[c];
      end
    end
  end

  // Channel output mux
  always_comb begin
    result_value = '0;
    for (int c = 0; c < `CONV_NB_OUT_CH; c++) begin
      if (out_ch == ch_idx_t'(c)) begin
        result_value = res[c];
      end
    end
  end

endmodule

/* conv_ctrl.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_ctrl import conv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_req,
  input  in_word_t in_word,
  input  logic     out_ack,
  input  acc_t     result_value,
  output logic     in_ack,
  output logic     shift_en,
  output logic     commit,
  output logic     kw_en,
  output ch_idx_t  kw_ch,
  output tap_idx_t kw_tap,
  output tap_idx_t rd_tap,
  output logic     step_valid,
  output logic     first_step,
  output logic     capture,
  output ch_idx_t  out_ch,
  output logic     out_req,
  output result_t  out_result
);

  // Step counter also covers the read latency and capture cycles
  localparam int STEP_W = $clog2(`CONV_NB_TAPS + 2);
  localparam logic [STEP_W-1:0] NB_STEPS = STEP_W'(`CONV_NB_TAPS);
  localparam logic [STEP_W-1:0] CAP_STEP = STEP_W'(`CONV_NB_TAPS + 1);
  localparam tap_idx_t LAST_TAP = tap_idx_t'(`CONV_NB_TAPS - 1);
  localparam ch_idx_t LAST_CH = ch_idx_t'(`CONV_NB_OUT_CH - 1);

  ctrl_state_e       state;
  logic [STEP_W-1:0] step;
  tap_idx_t          fill_cnt;  // Taps already in the filling window
  logic              fill_full; // Filling window waits for commit
  logic              kern_ok;
  logic              feat_ok;
  logic              accept;
  logic              fill_done;

  // Weights may change only when no window is queued or being processed
  assign kern_ok   = (state == IDLE) && !fill_full;
  assign feat_ok   = !fill_full;
  assign accept    = in_req && !in_ack && (in_word.kind ? kern_ok : feat_ok);
  assign shift_en  = accept && !in_word.kind;
  assign kw_en     = accept && in_word.kind;
  assign fill_done = shift_en && (fill_cnt == LAST_TAP);

  assign commit     = (state == COMMIT);
  assign step_valid = (state == RUN) && (step < NB_STEPS);
  assign first_step = step_valid && (step == '0);
  assign rd_tap     = step_valid ? tap_idx_t'(step) : '0;
  assign capture    = (state == RUN) && (step == CAP_STEP);
  assign out_result = '{ch: out_ch, value: result_value};

  // Input handshake, kernel write address and fill tracking
  always_ff @(posedge clk) begin
    if (rst) begin
      in_ack    <= 1'b0;
      kw_ch     <= '0;
      kw_tap    <= '0;
      fill_cnt  <= '0;
      fill_full <= 1'b0;
    end else begin
      if (accept) begin
        in_ack <= 1'b1;
      end else if (in_ack && !in_req) begin
        in_ack <= 1'b0; // Host has dropped req
      end
      if (kw_en) begin
        if (kw_tap == LAST_TAP) begin
          kw_tap <= '0;
          kw_ch  <= (kw_ch == LAST_CH) ? '0 : kw_ch + 1'b1; // Wrap after a full set
        end else begin
          kw_tap <= kw_tap + 1'b1;
        end
      end
      if (fill_done) begin
        fill_cnt  <= '0;
        fill_full <= 1'b1;
      end else if (shift_en) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
      if (commit) begin
        fill_full <= 1'b0;
      end
    end
  end

  // Compute sequencing and result drain
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      step    <= '0;
      out_req <= 1'b0;
      out_ch  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (fill_full || fill_done) begin
            state <= COMMIT;
          end
        end
        COMMIT: begin
          state <= RUN;
          step  <= '0;
        end
        RUN: begin
          step <= step + 1'b1;
          if (capture) begin
            state   <= DRAIN;
            out_ch  <= '0;
            out_req <= 1'b1; // Channel 0 goes out right after capture
          end
        end
        DRAIN: begin
          if (out_req && out_ack) begin
            out_req <= 1'b0;
          end else if (!out_req && !out_ack) begin
            if (out_ch == LAST_CH) begin
              state  <= IDLE;
              out_ch <= '0;
            end else begin
              out_ch  <= out_ch + 1'b1;
              out_req <= 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* conv_top.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_top import conv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_req,
  input  in_word_t in_word,
  output logic     in_ack,
  output logic     out_req,
  output result_t  out_result,
  input  logic     out_ack
);

  logic     shift_en;
  logic     commit;
  logic     kw_en;
  ch_idx_t  kw_ch;
  tap_idx_t kw_tap;
  tap_idx_t rd_tap;
  logic     step_valid;
  logic     first_step;
  logic     capture;
  ch_idx_t  out_ch;
  acc_t     result_value;

  data_t window [`CONV_NB_TAPS];   // Active window, stable during RUN
  data_t column [`CONV_NB_OUT_CH]; // Weights of one tap for every channel

  conv_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .in_req       (in_req),
    .in_word      (in_word),
    .out_ack      (out_ack),
    .result_value (result_value),
    .in_ack       (in_ack),
    .shift_en     (shift_en),
    .commit       (commit),
    .kw_en        (kw_en),
    .kw_ch        (kw_ch),
    .kw_tap       (kw_tap),
    .rd_tap       (rd_tap),
    .step_valid   (step_valid),
    .first_step   (first_step),
    .capture      (capture),
    .out_ch       (out_ch),
    .out_req      (out_req),
    .out_result   (out_result)
  );

  feature_window u_window (
    .clk      (clk),
    .rst      (rst),
    .shift_en (shift_en),
    .value    (in_word.value),
    .commit   (commit),
    .window   (window)
  );

  kernel_store u_kernel (
    .clk    (clk),
    .kw_en  (kw_en),
    .kw_ch  (kw_ch),
    .kw_tap (kw_tap),
    .value  (in_word.value),
    .rd_tap (rd_tap),
    .column (column)
  );

  mac_array u_mac (
    .clk          (clk),
    .rst          (rst),
    .window       (window),
    .column       (column),
    .rd_tap       (rd_tap),
    .step_valid   (step_valid),
    .first_step   (first_step),
    .capture      (capture),
    .out_ch       (out_ch),
    .result_value (result_value)
  );

endmodule

/* conv_sva.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_sva import conv_pkg::*; (
  input logic    clk,
  input logic    rst,
  input logic    in_req,
  input logic    in_ack,
  input logic    out_req,
  input result_t out_result,
  input logic    commit
);

  // Four-phase input side, ack holds until the host drops req
  in_ack_held: assert property (@(posedge clk) disable iff (rst)
    in_ack && in_req |=> in_ack)
    else $error("in_ack fell while in_req was high");

  result_stable: assert property (@(posedge clk) disable iff (rst)
    out_req |=> !out_req || $stable(out_result))
    else $error("out_result changed while out_req was high");

  quiet_reset: assert property (@(posedge clk) rst |=> !in_ack && !out_req)
    else $error("in_ack or out_req high after a reset cycle");

  // Commit leaves IDLE, so no earlier drain can still be running
  run_latency: assert property (@(posedge clk) disable iff (rst)
    commit |-> ##(`CONV_NB_TAPS + 3) $rose(out_req))
    else $error("out_req did not rise NB_TAPS+3 cycles after commit");

endmodule

bind conv_top conv_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .in_req     (in_req),
  .in_ack     (in_ack),
  .out_req    (out_req),
  .out_result (out_result),
  .commit     (commit)
);

/* conv_tb.sv */
`timescale 1ns/1ps
`include "conv_settings.svh"

module conv_tb import conv_pkg::*; ();

  localparam int NB_ROWS = 10;
  localparam int TIMEOUT = 5000; // Cycles allowed for any single wait

  logic     clk = 1'b0;
  logic     rst;
  logic     in_req;
  in_word_t in_word;
  logic     in_ack;
  logic     out_req;
  result_t  out_result;
  logic     out_ack;

  // Stimulus table, one row per feature window
  string name_tab [NB_ROWS];
  bit    reload_tab [NB_ROWS]; // Load a new kernel set before the window
  bit    b2b_tab [NB_ROWS];    // Next row starts without waiting for the drain
  int    hold_tab [NB_ROWS];   // Cycles out_ack is held off per result
  data_t w_tab [NB_ROWS][`CONV_NB_OUT_CH][`CONV_NB_TAPS];
  data_t f_tab [NB_ROWS][`CONV_NB_TAPS];
  acc_t  exp_tab [NB_ROWS][`CONV_NB_OUT_CH];

  // Results still owed by the DUT, oldest first
  acc_t        exp_val [$];
  ch_idx_t     exp_ch [$];
  int          exp_row [$];
  int          errors = 0;
  int          timeouts = 0;
  logic [31:0] lcg_state = 32'h83b522b5;

  conv_top dut (.*);

  always #50 clk = ~clk;

  function automatic data_t lcg_value();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return data_t'(lcg_state[31:16]); // Upper bits have the longest period
  endfunction

  // Wrapping sum of weight times feature over all taps
  // The first feature sent sits at tap 0
  function automatic acc_t dot(input int r, input int c);
    acc_t sum;
    sum = '0;
    for (int t = 0; t < `CONV_NB_TAPS; t++) begin
      sum += acc_t'(w_tab[r][c][t]) * acc_t'(f_tab[r][t]);
    end
    return sum;
  endfunction

  task automatic build_table();
    name_tab = '{"basic", "signed", "wrap", "overlap_a", "overlap_b", "reload_in_drain",
                 "slow_ack", "random_0", "random_1", "random_2"};
    reload_tab = '{1, 1, 1, 1, 0, 1, 0, 1, 0, 1};
    b2b_tab    = '{0, 0, 0, 1, 1, 0, 0, 1, 1, 0};
    hold_tab   = '{0, 3, 0, 20, 30, 0, 400, 0, 7, 0};
    for (int r = 0; r < NB_ROWS; r++) begin
      for (int t = 0; t < `CONV_NB_TAPS; t++) begin
        case (r)
          0:       f_tab[r][t] = data_t'(t + 1);
          1:       f_tab[r][t] = data_t'(50 - 37 * t);
          2:       f_tab[r][t] = data_t'(-32768); // Sum of nine 2**30 terms wraps
          default: f_tab[r][t] = lcg_value();
        endcase
        for (int c = 0; c < `CONV_NB_OUT_CH; c++) begin
          case (r)
            0:       w_tab[r][c][t] = data_t'(10 * c + t);
            1:       w_tab[r][c][t] = data_t'((t - 4) * (c + 1) * 100);
            2:       w_tab[r][c][t] = data_t'(-32768);
            default: w_tab[r][c][t] = reload_tab[r] ? lcg_value() : w_tab[r-1][c][t];
          endcase
        end
      end
      for (int c = 0; c < `CONV_NB_OUT_CH; c++) begin
        exp_tab[r][c] = dot(r, c);
      end
    end
  endtask

  // 0 selects in_ack, 1 selects out_req, 2 tells whether results are pending
  function automatic logic probe(input int sel);
    return (sel == 0) ? in_ack : (sel == 1) ? out_req : logic'(exp_val.size() != 0);
  endfunction

  task automatic wait_level(input int sel, input logic level, input string what);
    int n;
    n = 0;
    while (probe(sel) !== level && n < TIMEOUT && timeouts == 0) begin
      @(negedge clk);
      n++;
    end
    if (probe(sel) !== level && n >= TIMEOUT) begin
      $display("Timeout: %s", what);
      timeouts++;
    end
  endtask

  task automatic send_word(input logic is_kernel, input data_t val);
    in_word = '{kind: is_kernel, value: val};
    in_req  = 1'b1;
    wait_level(0, 1'b1, "in_ack never rose");
    if (is_kernel && exp_val.size() != 0) begin
      $display("Kernel word was acknowledged before earlier results were drained");
      errors++;
    end
    in_req = 1'b0;
    wait_level(0, 1'b0, "in_ack never fell");
  endtask

  task automatic receive_result();
    string name;
    name = name_tab[exp_row[0]];
    wait_level(1, 1'b1, {"no result arrived for ", name});
    check_ch(name, exp_ch[0], out_result.ch);
    check_acc(name, exp_val[0], out_result.value);
    repeat (hold_tab[exp_row[0]]) @(negedge clk); // Back-pressure on the output port
    out_ack = 1'b1;
    wait_level(1, 1'b0, "out_req stayed high after out_ack");
    out_ack = 1'b0;
    void'(exp_val.pop_front());
    void'(exp_ch.pop_front());
    void'(exp_row.pop_front());
  endtask

  task automatic check_acc(input string name, input acc_t expected, input acc_t actual);
    if (actual !== expected) begin
      $display("Error %s: expected %0d, actual %0d", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_ch(input string name, input ch_idx_t expected, input ch_idx_t actual);
    if (actual !== expected) begin
      $display("Error %s: expected channel %0d, actual channel %0d", name, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // Output side runs on its own so that windows can overlap
  initial begin
    forever begin
      @(negedge clk);
      if (exp_val.size() != 0) begin
        receive_result();
      end
    end
  end

  initial begin
    rst     = 1'b1;
    in_req  = 1'b0;
    in_word = '0;
    out_ack = 1'b0;
    build_table();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < NB_ROWS; r++) begin
      if (reload_tab[r]) begin
        for (int c = 0; c < `CONV_NB_OUT_CH; c++) begin
          for (int t = 0; t < `CONV_NB_TAPS; t++) begin
            send_word(1'b1, w_tab[r][c][t]); // Channel-major order
          end
        end
      end
      for (int c = 0; c < `CONV_NB_OUT_CH; c++) begin
        exp_val.push_back(exp_tab[r][c]);
        exp_ch.push_back(ch_idx_t'(c));
        exp_row.push_back(r);
      end
      for (int t = 0; t < `CONV_NB_TAPS; t++) begin
        send_word(1'b0, f_tab[r][t]);
      end
      if (!b2b_tab[r]) begin
        wait_level(2, 1'b0, "results of a window were never drained");
      end
    end
    wait_level(2, 1'b0, "results of the last window were never drained");
    repeat (20) @(negedge clk);
    if (out_req) begin
      $display("DUT raised a result that no window was owed");
      errors++;
    end
    finish_run();
  end

endmodule

/* sim.f */
+incdir+.
conv_pkg.sv
feature_window.sv
kernel_store.sv
mac_array.sv
conv_ctrl.sv
conv_top.sv
conv_sva.sv
conv_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module conv_tb -f sim.f
./obj_dir/Vconv_tb | tee sim.log

# Pass only when the testbench printed its pass line
if grep -qx "sim passed" sim.log; then
  exit 0
fi
echo "Simulation did not pass, see sim.log" >&2
exit 1
